// ==== src.f ====
cache_pkg.sv
cache_way.sv
cache_ctrl.sv
mem_arbiter.sv
line_mem.sv
cache_top.sv
tb_cache.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cache -f src.f \
    -o tb_cache_sim \
    && ./obj_dir/tb_cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0

// ==== tb_cache.sv ====
// tb_cache
// table-driven testbench for the two-port cache subsystem, checked against
// a byte-wide memory model and a per-cache tag and LRU model
`timescale 1ns/1ns

module tb_cache;
    import cache_pkg::*;

    typedef struct packed {
        logic  join_next; // issue in the same cycle as the next entry
        logic  port;      // 0 = a, 1 = b
        logic  write;
        logic  rnd;       // store data comes from the lcg
        size_t size;
        addr_t addr;
        word_t wdata;
    } entry_t;

    localparam int TIMEOUT_CYCLES = 200;

    logic        clk;
    logic        rst_n;
    logic        req_a;
    logic        req_b;
    cpu_req_t    cpu_a;
    cpu_req_t    cpu_b;
    logic        done_a;
    logic        done_b;
    word_t       rdata_a;
    word_t       rdata_b;
    logic        hit_a;
    logic        hit_b;

    entry_t      table_q [$];
    logic [7:0]  ref_mem [4096];             // expected memory, one byte per address
    logic        m_valid [2][NUM_SETS][NUM_WAYS];
    tag_t        m_tag   [2][NUM_SETS][NUM_WAYS];
    logic        m_dirty [2][NUM_SETS][NUM_WAYS];
    logic        m_lru   [2][NUM_SETS];
    logic [31:0] lcg_state;
    logic        exp_hit   [2];
    word_t       exp_rdata [2];
    logic        is_load   [2];
    logic        got_hit   [2];
    word_t       got_rdata [2];
    int          got_lat   [2];
    int          err_data;
    int          err_hit;
    int          err_lat;
    int          err_timeout;

    cache_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_a   (req_a),
        .cpu_a   (cpu_a),
        .done_a  (done_a),
        .rdata_a (rdata_a),
        .hit_a   (hit_a),
        .req_b   (req_b),
        .cpu_b   (cpu_b),
        .done_b  (done_b),
        .rdata_b (rdata_b),
        .hit_b   (hit_b)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // zero-extended little-endian load from the memory model
    function automatic word_t load_expect(addr_t a, size_t sz);
        word_t v;
        v = {24'b0, ref_mem[a]};
        if (sz == SIZE_HALF) begin
            v = {16'b0, ref_mem[a + 12'd1], ref_mem[a]};
        end else if (sz == SIZE_WORD) begin
            v = {ref_mem[a + 12'd3], ref_mem[a + 12'd2], ref_mem[a + 12'd1], ref_mem[a]};
        end
        return v;
    endfunction

    task automatic store_model(addr_t a, size_t sz, word_t d);
        ref_mem[a] = d[7:0];
        if (sz != SIZE_BYTE) begin
            ref_mem[a + 12'd1] = d[15:8];
        end
        if (sz == SIZE_WORD) begin
            ref_mem[a + 12'd2] = d[23:16];
            ref_mem[a + 12'd3] = d[31:24];
        end
    endtask

    // predicts hit or miss and updates tags, dirty bits and LRU
    function automatic logic lookup_model(logic p, addr_t a, logic wr);
        index_t s;
        tag_t   t;
        logic   w;
        logic   h;
        s = a[7:4];
        t = a[11:8];
        h = 1'b0;
        w = m_lru[p][s];
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (m_valid[p][s][i] && m_tag[p][s][i] == t) begin
                h = 1'b1;
                w = 1'(i);
            end
        end
        if (!h) begin
            m_valid[p][s][w] = 1'b1;
            m_tag[p][s][w]   = t;
            m_dirty[p][s][w] = 1'b0;
        end
        if (wr) begin
            m_dirty[p][s][w] = 1'b1;
        end
        m_lru[p][s] = !w; // other way becomes LRU
        return h;
    endfunction

    task automatic push_entry(logic p, logic wr, logic rnd, size_t sz, addr_t a, word_t d);
        entry_t e;
        e.join_next = 1'b0;
        e.port      = p;
        e.write     = wr;
        e.rnd       = rnd;
        e.size      = sz;
        e.addr      = a;
        e.wdata     = d;
        table_q.push_back(e);
    endtask

    task automatic ld(logic p, size_t sz, addr_t a);
        push_entry(p, 1'b0, 1'b0, sz, a, 32'h0);
    endtask

    task automatic st(logic p, size_t sz, addr_t a, word_t d);
        push_entry(p, 1'b1, 1'b0, sz, a, d);
    endtask

    task automatic rand_st(logic p, size_t sz, addr_t a);
        push_entry(p, 1'b1, 1'b1, sz, a, 32'h0);
    endtask

    task automatic pair_last();
        entry_t e;
        e = table_q.pop_back();
        e.join_next = 1'b1;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // cold miss, then hits in the same line
        ld(0, SIZE_WORD, 12'h010);
        ld(0, SIZE_WORD, 12'h014);
        ld(0, SIZE_BYTE, 12'h013);
        ld(0, SIZE_HALF, 12'h01e);
        // byte, half and word stores merging into one line
        st(0, SIZE_BYTE, 12'h021, 32'h0000_00a5);
        st(0, SIZE_HALF, 12'h026, 32'h0000_beef);
        st(0, SIZE_WORD, 12'h028, 32'h1234_5678);
        st(0, SIZE_BYTE, 12'h02f, 32'hffff_ffc3);
        ld(0, SIZE_WORD, 12'h020);
        ld(0, SIZE_BYTE, 12'h021);
        ld(0, SIZE_HALF, 12'h026);
        ld(0, SIZE_WORD, 12'h028);
        ld(0, SIZE_HALF, 12'h02e);
        ld(0, SIZE_WORD, 12'h02c);
        // three tags fighting over set 3
        ld(0, SIZE_WORD, 12'h030);
        ld(0, SIZE_WORD, 12'h130);
        ld(0, SIZE_WORD, 12'h034);
        ld(0, SIZE_WORD, 12'h230);
        ld(0, SIZE_WORD, 12'h030);
        ld(0, SIZE_WORD, 12'h130);
        ld(0, SIZE_WORD, 12'h230);
        // dirty lines in set 5 pushed out and read back
        st(0, SIZE_WORD, 12'h050, 32'hdead_beef);
        st(0, SIZE_HALF, 12'h156, 32'h0000_cafe);
        st(0, SIZE_BYTE, 12'h25c, 32'h0000_003c);
        ld(0, SIZE_WORD, 12'h350);
        ld(0, SIZE_WORD, 12'h050);
        ld(0, SIZE_HALF, 12'h156);
        ld(0, SIZE_BYTE, 12'h25c);
        // random store data on port b, set 7
        rand_st(1, SIZE_WORD, 12'h870);
        rand_st(1, SIZE_WORD, 12'h974);
        rand_st(1, SIZE_BYTE, 12'ha7d);
        ld(1, SIZE_WORD, 12'h870);
        ld(1, SIZE_WORD, 12'h974);
        ld(1, SIZE_BYTE, 12'ha7d);
        // both ports at once, set c in disjoint regions
        ld(0, SIZE_WORD, 12'h0c0);
        pair_last();
        ld(1, SIZE_WORD, 12'hcc0);
        rand_st(0, SIZE_WORD, 12'h1c4);
        pair_last();
        rand_st(1, SIZE_WORD, 12'hdc4);
        st(0, SIZE_HALF, 12'h0c2, 32'h0000_7788);
        pair_last();
        st(1, SIZE_BYTE, 12'hcc3, 32'h0000_0099);
        ld(0, SIZE_WORD, 12'h2c8);
        pair_last();
        ld(1, SIZE_WORD, 12'hec8);
        ld(0, SIZE_WORD, 12'h1c4);
        pair_last();
        ld(1, SIZE_WORD, 12'hdc4);
        ld(0, SIZE_HALF, 12'h0c2);
        pair_last();
        ld(1, SIZE_BYTE, 12'hcc3);
    endtask

    // waits for done on the requested ports and captures hit, rdata, latency
    task automatic wait_done(logic need_a, logic need_b);
        logic seen_a;
        logic seen_b;
        int   n;
        seen_a = !need_a;
        seen_b = !need_b;
        n = 1;
        while (!(seen_a && seen_b) && err_timeout == 0) begin
            @(negedge clk);
            if (done_a && !seen_a) begin
                seen_a       = 1'b1;
                got_hit[0]   = hit_a;
                got_rdata[0] = rdata_a;
                got_lat[0]   = n;
            end
            if (done_b && !seen_b) begin
                seen_b       = 1'b1;
                got_hit[1]   = hit_b;
                got_rdata[1] = rdata_b;
                got_lat[1]   = n;
            end
            if (!(seen_a && seen_b)) begin
                if (n >= TIMEOUT_CYCLES) begin
                    if (!seen_a) begin
                        $display("port a did not signal done within %0d cycles", n);
                    end
                    if (!seen_b) begin
                        $display("port b did not signal done within %0d cycles", n);
                    end
                    err_timeout++;
                end else begin
                    @(posedge clk);
                    n++;
                end
            end
        end
    endtask

    task automatic check_result(int p, int id);
        string nm;
        nm = (p == 1) ? "b" : "a";
        if (got_hit[p] !== exp_hit[p]) begin
            err_hit++;
            $display("[ERROR] entry %0d: hit_%s expected 0x%h, actual 0x%h",
                     id, nm, exp_hit[p], got_hit[p]);
        end
        if (exp_hit[p] && got_lat[p] != 2) begin
            err_lat++;
            $display("[ERROR] entry %0d: done_%s latency expected 0x2, actual 0x%h",
                     id, nm, got_lat[p]);
        end
        if (is_load[p] && got_rdata[p] !== exp_rdata[p]) begin
            err_data++;
            $display("[ERROR] entry %0d: rdata_%s expected 0x%h, actual 0x%h",
                     id, nm, exp_rdata[p], got_rdata[p]);
        end
    endtask

    task automatic run_table();
        entry_t   e;
        cpu_req_t c;
        int       i;
        int       cnt;
        logic     need [2];
        i = 0;
        while (i < table_q.size() && err_timeout == 0) begin
            cnt = table_q[i].join_next ? 2 : 1;
            need[0] = 1'b0;
            need[1] = 1'b0;
            @(posedge clk);
            #2;
            for (int k = 0; k < cnt; k++) begin
                e = table_q[i + k];
                c.write = e.write;
                c.size  = e.size;
                c.addr  = e.addr;
                c.wdata = e.rnd ? lcg_next() : e.wdata;
                need[e.port]    = 1'b1;
                is_load[e.port] = !e.write;
                exp_hit[e.port] = lookup_model(e.port, e.addr, e.write);
                if (e.write) begin
                    store_model(e.addr, e.size, c.wdata);
                end else begin
                    exp_rdata[e.port] = load_expect(e.addr, e.size);
                end
                if (e.port) begin
                    req_b = 1'b1;
                    cpu_b = c;
                end else begin
                    req_a = 1'b1;
                    cpu_a = c;
                end
            end
            @(posedge clk);
            #2;
            req_a = 1'b0; // one-cycle strobe
            req_b = 1'b0;
            wait_done(need[0], need[1]);
            for (int p = 0; p < 2; p++) begin
                if (need[p] && err_timeout == 0) begin
                    check_result(p, i);
                end
            end
            i += cnt;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_a       = 1'b0;
        req_b       = 1'b0;
        cpu_a       = '0;
        cpu_b       = '0;
        lcg_state   = 32'hc214;
        err_data    = 0;
        err_hit     = 0;
        err_lat     = 0;
        err_timeout = 0;
        for (int a = 0; a < 4096; a++) begin
            ref_mem[a] = 8'(a) ^ 8'h5a; // same rule as line_mem reset
        end
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                m_lru[p][s] = 1'b0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    m_valid[p][s][w] = 1'b0;
                    m_dirty[p][s][w] = 1'b0;
                    m_tag[p][s][w]   = '0;
                end
            end
        end
        build_table();
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        run_table();
        $display("errors: data %0d, hit %0d, latency %0d, timeout %0d",
                 err_data, err_hit, err_lat, err_timeout);
        if (err_data + err_hit + err_lat + err_timeout == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== cache_top.sv ====
// cache_top
// two peer caches sharing one backing memory through a round-robin arbiter
`timescale 1ns/1ns

module cache_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_a,
    input  cache_pkg::cpu_req_t cpu_a,
    output logic                done_a,
    output cache_pkg::word_t    rdata_a,
    output logic                hit_a,
    input  logic                req_b,
    input  cache_pkg::cpu_req_t cpu_b,
    output logic                done_b,
    output cache_pkg::word_t    rdata_b,
    output logic                hit_b
);
    import cache_pkg::*;

    logic     mem_req_a;
    logic     mem_req_b;
    mem_req_t mem_a;
    mem_req_t mem_b;
    logic     mem_ack_a;
    logic     mem_ack_b;
    line_t    mem_rdata_a;
    line_t    mem_rdata_b;
    logic     bus_req;
    mem_req_t bus;
    logic     bus_ack;
    line_t    bus_rdata;

    cache_ctrl u_cache_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_a),
        .cpu       (cpu_a),
        .done      (done_a),
        .rdata     (rdata_a),
        .hit       (hit_a),
        .mem_req   (mem_req_a),
        .mem       (mem_a),
        .mem_ack   (mem_ack_a),
        .mem_rdata (mem_rdata_a)
    );

    cache_ctrl u_cache_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_b),
        .cpu       (cpu_b),
        .done      (done_b),
        .rdata     (rdata_b),
        .hit       (hit_b),
        .mem_req   (mem_req_b),
        .mem       (mem_b),
        .mem_ack   (mem_ack_b),
        .mem_rdata (mem_rdata_b)
    );

    mem_arbiter u_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_a     (mem_req_a),
        .req_b     (mem_req_b),
        .mem_a     (mem_a),
        .mem_b     (mem_b),
        .ack_a     (mem_ack_a),
        .ack_b     (mem_ack_b),
        .rdata_a   (mem_rdata_a),
        .rdata_b   (mem_rdata_b),
        .bus_req   (bus_req),
        .bus       (bus),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata)
    );

    line_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus       (bus),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata)
    );

endmodule

// ==== line_mem.sv ====
// line_mem
// backing store of 256 lines, one line per access, ack one cycle after req
// contents come up as byte address ^ 8'h5a
`timescale 1ns/1ns

module line_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                bus_req,
    input  cache_pkg::mem_req_t bus,
    output logic                bus_ack,
    output cache_pkg::line_t    bus_rdata
);
    import cache_pkg::*;

    line_t mem_q [MEM_LINES];
    logic  accept;

    // requester drops req in the ack cycle, so no back-to-back ack
    assign accept = bus_req && !bus_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_ack <= 1'b0;
            for (int i = 0; i < MEM_LINES; i++) begin
                for (int b = 0; b < LINE_BYTES; b++) begin
                    mem_q[i][b*8 +: 8] <= 8'(i * LINE_BYTES + b) ^ 8'h5a;
                end
            end
        end else begin
            bus_ack <= accept;
            if (accept && bus.write) begin
                mem_q[bus.line_addr] <= bus.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus_rdata <= mem_q[bus.line_addr]; // old data on a write, unused
        end
    end

endmodule

// ==== mem_arbiter.sv ====
// mem_arbiter
// round-robin arbiter for two caches on one line-wide memory bus,
// owner held until the memory acknowledges
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_a,
    input  logic                req_b,
    input  cache_pkg::mem_req_t mem_a,
    input  cache_pkg::mem_req_t mem_b,
    output logic                ack_a,
    output logic                ack_b,
    output cache_pkg::line_t    rdata_a,
    output cache_pkg::line_t    rdata_b,
    output logic                bus_req,
    output cache_pkg::mem_req_t bus,
    input  logic                bus_ack,
    input  cache_pkg::line_t    bus_rdata
);
    import cache_pkg::*;

    logic busy;
    logic owner;   // 0 = a, 1 = b
    logic prio;    // who wins a tie
    logic winner;
    logic gnt_a;
    logic gnt_b;

    assign winner = (req_a && req_b) ? prio : req_b;
    assign gnt_a  = busy && !owner;
    assign gnt_b  = busy && owner;

    assign bus_req = (gnt_a && req_a) || (gnt_b && req_b);
    assign bus     = owner ? mem_b : mem_a;

    assign ack_a   = gnt_a && bus_ack;
    assign ack_b   = gnt_b && bus_ack;
    assign rdata_a = gnt_a ? bus_rdata : '0;
    assign rdata_b = gnt_b ? bus_rdata : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
        end else if (!busy) begin
            if (req_a || req_b) begin
                busy  <= 1'b1;
                owner <= winner;
            end
        end else if (bus_ack) begin
            busy <= 1'b0;
            prio <= ~owner; // other side goes first next time
        end
    end

    a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(ack_a && ack_b));

    a_owner_locked: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req && !bus_ack |=> $stable(owner));

endmodule

// ==== cache_ctrl.sv ====
// cache_ctrl
// blocking 2-way write-back, write-allocate cache with a lookup, victim
// write-back and refill FSM and one LRU bit per set
`timescale 1ns/1ns

module cache_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  cache_pkg::cpu_req_t cpu,
    output logic                done,
    output cache_pkg::word_t    rdata,
    output logic                hit,
    output logic                mem_req,
    output cache_pkg::mem_req_t mem,
    input  logic                mem_ack,
    input  cache_pkg::line_t    mem_rdata
);
    import cache_pkg::*;

    ctrl_state_t         state;
    cpu_req_t            cpu_q;
    logic                victim_q;
    logic                refilled;
    logic                lru [NUM_SETS]; // index of the least recently used way
    index_t              idx;
    tag_t                tag;
    offset_t             off;
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_dirty;
    logic [NUM_WAYS-1:0] fill_w;
    logic [NUM_WAYS-1:0] store_w;
    tag_t                way_tag  [NUM_WAYS];
    line_t               way_line [NUM_WAYS];
    line_t               hit_line;
    word_t               load_val;
    logic                any_hit;
    logic                victim_way;
    logic                refill_done;

    assign idx = addr_index(cpu_q.addr);
    assign tag = addr_tag(cpu_q.addr);
    assign off = addr_offset(cpu_q.addr);

    assign any_hit     = |way_hit;
    assign hit_line    = way_line[way_hit[1]];
    assign victim_way  = lru[idx];
    assign refill_done = (state == REFILL) && mem_ack;

    assign fill_w[0]  = refill_done && !victim_q;
    assign fill_w[1]  = refill_done && victim_q;
    assign store_w    = (state == LOOKUP && cpu_q.write) ? way_hit : '0;

    cache_way u_way0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (idx),
        .tag        (tag),
        .fill       (fill_w[0]),
        .fill_line  (mem_rdata),
        .store      (store_w[0]),
        .offset     (off),
        .size       (cpu_q.size),
        .wdata      (cpu_q.wdata),
        .hit        (way_hit[0]),
        .dirty      (way_dirty[0]),
        .victim_tag (way_tag[0]),
        .line       (way_line[0])
    );

    cache_way u_way1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (idx),
        .tag        (tag),
        .fill       (fill_w[1]),
        .fill_line  (mem_rdata),
        .store      (store_w[1]),
        .offset     (off),
        .size       (cpu_q.size),
        .wdata      (cpu_q.wdata),
        .hit        (way_hit[1]),
        .dirty      (way_dirty[1]),
        .victim_tag (way_tag[1]),
        .line       (way_line[1])
    );

    // zero-extended load data from the hitting way
    always_comb begin
        case (cpu_q.size)
            SIZE_BYTE: load_val = {24'b0, hit_line[{off, 3'b000} +: 8]};
            SIZE_HALF: load_val = {16'b0, hit_line[{off[3:1], 4'b0000} +: 16]};
            default:   load_val = hit_line[{off[3:2], 5'b00000} +: 32];
        endcase
    end

    // memory request, victim line first on a dirty miss
    assign mem_req = (state == WRITE_BACK) || (state == REFILL);

    always_comb begin
        mem.write = (state == WRITE_BACK);
        if (state == WRITE_BACK) begin
            mem.line_addr = {way_tag[victim_q], idx};
            mem.data      = way_line[victim_q];
        end else begin
            mem.line_addr = {tag, idx};
            mem.data      = '0;
        end
    end

    assign done = (state == RESPOND);
    assign hit  = !refilled; // second lookup after a refill always hits

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            victim_q <= 1'b0;
            refilled <= 1'b0;
            for (int i = 0; i < NUM_SETS; i++) begin
                lru[i] <= 1'b0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        refilled <= 1'b0;
                        state    <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (any_hit) begin
                        lru[idx] <= ~way_hit[1]; // other way becomes LRU
                        state    <= RESPOND;
                    end else begin
                        victim_q <= victim_way;
                        state    <= way_dirty[victim_way] ? WRITE_BACK : REFILL;
                    end
                end
                WRITE_BACK: begin
                    if (mem_ack) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_ack) begin
                        refilled <= 1'b1;
                        state    <= LOOKUP; // replay the access on the new line
                    end
                end
                RESPOND: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            cpu_q <= cpu;
        end
        if (state == LOOKUP && any_hit && !cpu_q.write) begin
            rdata <= load_val;
        end
    end

    // request must be held until the arbiter returns ack
    a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req && $stable(mem));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done);

endmodule

// ==== cache_way.sv ====
// cache_way
// one way of the cache with valid, dirty, tag and line storage per set,
// tag compare and byte-lane store merge
`timescale 1ns/1ns

module cache_way (
    input  logic               clk,
    input  logic               rst_n,
    input  cache_pkg::index_t  index,
    input  cache_pkg::tag_t    tag,
    input  logic               fill,
    input  cache_pkg::line_t   fill_line,
    input  logic               store,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::size_t   size,
    input  cache_pkg::word_t   wdata,
    output logic               hit,
    output logic               dirty,
    output cache_pkg::tag_t    victim_tag,
    output cache_pkg::line_t   line
);
    import cache_pkg::*;

    logic  valid_q [NUM_SETS];
    logic  dirty_q [NUM_SETS];
    tag_t  tag_q   [NUM_SETS];
    line_t data_q  [NUM_SETS];
    line_t merged;

    assign line       = data_q[index];
    assign victim_tag = tag_q[index];
    assign hit        = valid_q[index] && (tag_q[index] == tag);
    assign dirty      = valid_q[index] && dirty_q[index]; // only a valid line needs write-back

    // overlay the store bytes on the current line
    always_comb begin
        merged = data_q[index];
        case (size)
            SIZE_BYTE: merged[{offset, 3'b000} +: 8]         = wdata[7:0];
            SIZE_HALF: merged[{offset[3:1], 4'b0000} +: 16]  = wdata[15:0];
            default:   merged[{offset[3:2], 5'b00000} +: 32] = wdata;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_SETS; i++) begin
                valid_q[i] <= 1'b0;
                dirty_q[i] <= 1'b0;
            end
        end else if (fill) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0; // fresh from memory
        end else if (store) begin
            dirty_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            data_q[index] <= fill_line;
            tag_q[index]  <= tag;
        end else if (store) begin
            data_q[index] <= merged;
        end
    end

endmodule

// ==== cache_pkg.sv ====
// cache_pkg
// shared types, sizes and state encodings for the two-port cache subsystem
// 2 ways x 16 sets x 16-byte lines over a 12-bit byte address space
package cache_pkg;

    typedef logic [11:0]  addr_t;
    typedef logic [3:0]   tag_t;      // addr[11:8]
    typedef logic [3:0]   index_t;    // addr[7:4]
    typedef logic [3:0]   offset_t;   // addr[3:0]
    typedef logic [7:0]   line_addr_t; // {tag, index}
    typedef logic [31:0]  word_t;
    typedef logic [127:0] line_t;
    typedef logic [1:0]   size_t;

    localparam int NUM_SETS   = 16;
    localparam int NUM_WAYS   = 2;
    localparam int LINE_BYTES = 16;
    localparam int MEM_LINES  = 256;

    // size codes as used by the cpu side
    localparam size_t SIZE_WORD = 2'd0;
    localparam size_t SIZE_BYTE = 2'd1;
    localparam size_t SIZE_HALF = 2'd2;

    typedef struct packed {
        logic  write;
        size_t size;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic       write;
        line_addr_t line_addr;
        line_t      data;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        RESPOND
    } ctrl_state_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[11:8];
    endfunction

    function automatic index_t addr_index(addr_t a);
        return a[7:4];
    endfunction

    function automatic offset_t addr_offset(addr_t a);
        return a[3:0];
    endfunction

endpackage
